// File: rtl/chan_pkg.sv
package chan_pkg;

  localparam int LSAB_DEPTH = 4;

  typedef logic [31:0] word_t;

  // 0 to LSAB_DEPTH, so one bit wider than a pointer.
  typedef logic [2:0] occ_t;

  typedef struct packed {
    word_t data;
    logic  last; // set on the word that ends a frame.
  } chan_word_t;

endpackage

// File: rtl/net_pkg.sv
package net_pkg;

  // start, 32 data bits lsb first, last flag, stop.
  localparam int FRAME_BITS = 35;

  localparam int RST_HOLD = 16; // cycles the core stays in reset after RST.

  typedef logic [5:0] bit_idx_t;
  typedef logic [4:0] hold_t;

  typedef enum logic {
    TX_IDLE,
    TX_SHIFT
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_SHIFT,
    RX_STORE
  } rx_state_t;

endpackage

// File: rtl/reset_sequencer.sv
module reset_sequencer (
  input  logic CPU_CLK,
  input  logic RST,
  output logic rst_core,
  output logic ready
);
  net_pkg::hold_t hold_cnt;
  logic           hold_done;

  assign hold_done = (hold_cnt == net_pkg::hold_t'(net_pkg::RST_HOLD));

  // saturates, so the core stays out of reset until RST drops again.
  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      hold_cnt <= '0;
    end else if (!hold_done) begin
      hold_cnt <= hold_cnt + 5'd1;
    end
  end

  assign rst_core = hold_done; // active low, released at the end of the hold.
  assign ready    = hold_done;

endmodule

// File: rtl/host_port.sv
module host_port (
  input  logic                 CPU_CLK,
  input  logic                 rst_core,
  input  logic                 send_req,
  input  chan_pkg::chan_word_t send_word,
  output logic                 send_ack,
  output logic                 recv_req,
  output chan_pkg::chan_word_t recv_word,
  input  logic                 recv_ack,
  output logic                 err,
  input  logic                 err_ack,
  output logic                 tx_push,
  output chan_pkg::chan_word_t tx_push_word,
  input  chan_pkg::occ_t       tx_occ,
  output logic                 rx_pop,
  input  chan_pkg::chan_word_t rx_head,
  input  chan_pkg::occ_t       rx_occ,
  input  logic                 overflow
);
  typedef enum logic {SEND_IDLE, SEND_ACK} send_state_t;
  typedef enum logic [1:0] {RECV_IDLE, RECV_REQ, RECV_DONE} recv_state_t;
  typedef enum logic [1:0] {ERR_IDLE, ERR_SET, ERR_CLEAR} err_state_t;

  send_state_t send_state;
  recv_state_t recv_state;
  err_state_t  err_state;
  logic        tx_full;
  logic        rx_empty;

  assign tx_full  = (tx_occ == chan_pkg::occ_t'(chan_pkg::LSAB_DEPTH));
  assign rx_empty = (rx_occ == '0);

  // push goes out in the cycle the request is accepted, ack follows.
  assign tx_push      = (send_state == SEND_IDLE) && send_req && !tx_full;
  assign tx_push_word = send_word;
  assign send_ack     = (send_state == SEND_ACK);

  assign recv_req  = (recv_state == RECV_REQ);
  assign recv_word = rx_head; // head only moves on our own pop.
  assign rx_pop    = (recv_state == RECV_REQ) && recv_ack;

  assign err = (err_state == ERR_SET);

  always_ff @(posedge CPU_CLK) begin
    if (!rst_core) begin
      send_state <= SEND_IDLE;
      recv_state <= RECV_IDLE;
      err_state  <= ERR_IDLE;
    end else begin
      case (send_state)
        SEND_IDLE: if (tx_push) send_state <= SEND_ACK;
        default:   if (!send_req) send_state <= SEND_IDLE;
      endcase

      case (recv_state)
        RECV_IDLE: if (!rx_empty) recv_state <= RECV_REQ;
        RECV_REQ:  if (recv_ack) recv_state <= RECV_DONE;
        default:   if (!recv_ack) recv_state <= RECV_IDLE; // wait for ack to drop.
      endcase

      // overflows arriving while err is set or still being acked are lost.
      case (err_state)
        ERR_IDLE: if (overflow) err_state <= ERR_SET;
        ERR_SET:  if (err_ack) err_state <= ERR_CLEAR;
        default:  if (!err_ack) err_state <= ERR_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/lsab_buffer.sv
module lsab_buffer (
  input  logic                 CPU_CLK,
  input  logic                 rst_core,
  input  logic                 push,
  input  chan_pkg::chan_word_t push_word,
  input  logic                 pop,
  output chan_pkg::chan_word_t head_word,
  output chan_pkg::occ_t       occ,
  output chan_pkg::occ_t       last_count
);
  chan_pkg::chan_word_t mem [chan_pkg::LSAB_DEPTH];
  logic [1:0]           wr_ptr;
  logic [1:0]           rd_ptr;
  logic                 do_push;
  logic                 do_pop;

  assign do_pop  = pop && (occ != '0);
  // a full buffer still takes a push when the head leaves in the same cycle.
  assign do_push = push && ((occ != chan_pkg::occ_t'(chan_pkg::LSAB_DEPTH)) || do_pop);

  assign head_word = mem[rd_ptr];

  always_ff @(posedge CPU_CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (!rst_core) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occ        <= '0;
      last_count <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 2'd1;
      if (do_pop) rd_ptr <= rd_ptr + 2'd1;

      case ({do_push, do_pop})
        2'b10:   occ <= occ + 3'd1;
        2'b01:   occ <= occ - 3'd1;
        default: occ <= occ;
      endcase

      // frame ends held, drives the interrupt.
      last_count <= last_count
                    + chan_pkg::occ_t'(do_push && push_word.last)
                    - chan_pkg::occ_t'(do_pop && head_word.last);
    end
  end

endmodule

// File: rtl/frame_sender.sv
module frame_sender (
  input  logic                 CPU_CLK,
  input  logic                 rst_core,
  input  chan_pkg::occ_t       tx_occ,
  input  chan_pkg::chan_word_t tx_head,
  output logic                 tx_pop,
  output logic                 wire_tx
);
  net_pkg::tx_state_t            state;
  net_pkg::bit_idx_t             bit_idx;
  logic [net_pkg::FRAME_BITS-1:0] shreg;
  logic                          frame_end;
  logic                          load;

  assign frame_end = (bit_idx == net_pkg::bit_idx_t'(net_pkg::FRAME_BITS - 1));

  // reload on the stop bit so frames leave back to back.
  assign load = ((state == net_pkg::TX_IDLE) ||
                 (state == net_pkg::TX_SHIFT && frame_end)) &&
                (tx_occ != '0);

  assign tx_pop  = load;
  assign wire_tx = (state == net_pkg::TX_SHIFT) ? shreg[0] : 1'b1; // line idles high.

  always_ff @(posedge CPU_CLK) begin
    if (!rst_core) begin
      state   <= net_pkg::TX_IDLE;
      bit_idx <= '0;
    end else begin
      case (state)
        net_pkg::TX_IDLE: begin
          if (load) begin
            state   <= net_pkg::TX_SHIFT;
            bit_idx <= '0;
          end
        end
        default: begin
          if (load) begin
            bit_idx <= '0;
          end else if (frame_end) begin
            state <= net_pkg::TX_IDLE;
          end else begin
            bit_idx <= bit_idx + 6'd1;
          end
        end
      endcase
    end
  end

  // stop, last, data, start; bit 0 goes out first.
  always_ff @(posedge CPU_CLK) begin
    if (load) begin
      shreg <= {1'b1, tx_head.last, tx_head.data, 1'b0};
    end else if (state == net_pkg::TX_SHIFT) begin
      shreg <= {1'b1, shreg[net_pkg::FRAME_BITS-1:1]};
    end
  end

endmodule

// File: rtl/frame_receiver.sv
module frame_receiver (
  input  logic                 CPU_CLK,
  input  logic                 rst_core,
  input  logic                 wire_rx,
  input  chan_pkg::occ_t       rx_occ,
  output logic                 rx_push,
  output chan_pkg::chan_word_t rx_push_word,
  output logic                 overflow
);
  net_pkg::rx_state_t             state;
  net_pkg::bit_idx_t              bit_idx;
  logic [net_pkg::FRAME_BITS-2:0] shreg; // everything after the start bit.
  logic                           rx_full;
  logic                           stop_ok;
  logic                           frame_end;

  assign rx_full   = (rx_occ == chan_pkg::occ_t'(chan_pkg::LSAB_DEPTH));
  assign stop_ok   = shreg[net_pkg::FRAME_BITS-2];
  assign frame_end = (bit_idx == net_pkg::bit_idx_t'(net_pkg::FRAME_BITS - 1));

  // bad stop bit drops the frame silently.
  assign rx_push      = (state == net_pkg::RX_STORE) && stop_ok && !rx_full;
  assign overflow     = (state == net_pkg::RX_STORE) && stop_ok && rx_full;
  assign rx_push_word = '{data: shreg[31:0], last: shreg[32]};

  always_ff @(posedge CPU_CLK) begin
    if (!rst_core) begin
      state   <= net_pkg::RX_IDLE;
      bit_idx <= '0;
    end else begin
      case (state)
        net_pkg::RX_SHIFT: begin
          bit_idx <= bit_idx + 6'd1;
          if (frame_end) state <= net_pkg::RX_STORE;
        end
        default: begin
          // the next start bit can already be on the line during store.
          if (!wire_rx) begin
            state   <= net_pkg::RX_SHIFT;
            bit_idx <= 6'd1;
          end else begin
            state <= net_pkg::RX_IDLE;
          end
        end
      endcase
    end
  end

  // lsb arrives first and ends up at bit 0.
  always_ff @(posedge CPU_CLK) begin
    if (state == net_pkg::RX_SHIFT) begin
      shreg <= {wire_rx, shreg[net_pkg::FRAME_BITS-2:1]};
    end
  end

endmodule

// File: rtl/chip.sv
module chip (
  input  logic                 CPU_CLK,
  input  logic                 RST,
  output logic                 ready,
  input  logic                 send_req,
  input  chan_pkg::chan_word_t send_word,
  output logic                 send_ack,
  output logic                 recv_req,
  output chan_pkg::chan_word_t recv_word,
  input  logic                 recv_ack,
  output logic                 err,
  input  logic                 err_ack,
  output logic                 irq,
  input  logic                 wire_rx,
  output logic                 wire_tx
);
  logic                 rst_core;
  logic                 tx_push;
  logic                 tx_pop;
  logic                 rx_push;
  logic                 rx_pop;
  logic                 overflow;
  chan_pkg::chan_word_t tx_push_word;
  chan_pkg::chan_word_t tx_head;
  chan_pkg::chan_word_t rx_push_word;
  chan_pkg::chan_word_t rx_head;
  chan_pkg::occ_t       tx_occ;
  chan_pkg::occ_t       rx_occ;
  chan_pkg::occ_t       rx_last;

  reset_sequencer rst_seq (.CPU_CLK, .RST, .rst_core, .ready);

  host_port host (.CPU_CLK, .rst_core, .send_req, .send_word, .send_ack,
                  .recv_req, .recv_word, .recv_ack, .err, .err_ack,
                  .tx_push, .tx_push_word, .tx_occ, .rx_pop, .rx_head, .rx_occ,
                  .overflow);

  lsab_buffer tx_buf (.CPU_CLK, .rst_core, .push(tx_push), .push_word(tx_push_word),
                      .pop(tx_pop), .head_word(tx_head), .occ(tx_occ), .last_count());

  lsab_buffer rx_buf (.CPU_CLK, .rst_core, .push(rx_push), .push_word(rx_push_word),
                      .pop(rx_pop), .head_word(rx_head), .occ(rx_occ), .last_count(rx_last));

  frame_sender sender (.CPU_CLK, .rst_core, .tx_occ, .tx_head, .tx_pop, .wire_tx);

  frame_receiver receiver (.CPU_CLK, .rst_core, .wire_rx, .rx_occ, .rx_push,
                           .rx_push_word, .overflow);

  assign irq = (rx_last != '0); // a complete frame is waiting.

endmodule

// File: verification/chip_tests.svh
  function automatic logic pick(input string name);
    case (name)
      "send_ack": return send_ack;
      "recv_req": return recv_req;
      "err":      return err;
      default:    return irq;
    endcase
  endfunction

  // outputs are read at the rising edge, before the DUT updates.
  task automatic wait_for(input string name, input logic level);
    waited = 0;
    do begin
      @(posedge CPU_CLK);
      waited++;
      if (waited > WAIT_LIMIT) abort_run($sformatf("timed out waiting for %s", name));
    end while (pick(name) !== level);
  endtask

  task automatic send_one(input chan_pkg::chan_word_t w);
    @(posedge CPU_CLK);
    send_req  <= 1'b1;
    send_word <= w;
    wait_for("send_ack", 1'b1);
    ack_wait = waited;
    send_req <= 1'b0;
    wait_for("send_ack", 1'b0);
  endtask

  task automatic recv_one(output chan_pkg::chan_word_t w, output logic irq_seen);
    wait_for("recv_req", 1'b1);
    w        = recv_word;
    irq_seen = irq;
    recv_ack <= 1'b1;
    wait_for("recv_req", 1'b0);
    recv_ack <= 1'b0;
  endtask

  // a frame holds at most 34 ones in a row, a longer run is an idle line.
  task automatic wait_line_idle();
    int quiet;
    quiet  = 0;
    waited = 0;
    while (quiet <= net_pkg::FRAME_BITS) begin
      @(posedge CPU_CLK);
      waited++;
      quiet = wire_tx ? quiet + 1 : 0;
      if (waited > WAIT_LIMIT) abort_run("wire_tx never went idle");
    end
  endtask

  task automatic drive_frame(input logic [net_pkg::FRAME_BITS-1:0] bits);
    for (int i = 0; i < net_pkg::FRAME_BITS; i++) begin
      @(posedge CPU_CLK);
      drv_rx <= bits[i]; // one bit per clock.
    end
    @(posedge CPU_CLK);
    drv_rx <= 1'b1;
  endtask

  task automatic reset_values();
    cur_test = "reset";
    // ready rises on edge RST_HOLD and is seen one edge later.
    repeat (net_pkg::RST_HOLD) @(posedge CPU_CLK);
    check_bit("ready during hold", 1'b0, ready);
    @(posedge CPU_CLK);
    check_bit("ready after hold", 1'b1, ready);
    check_bit("wire_tx", 1'b1, wire_tx);
    check_bit("send_ack", 1'b0, send_ack);
    check_bit("recv_req", 1'b0, recv_req);
    check_bit("err", 1'b0, err);
    check_bit("irq", 1'b0, irq);
  endtask

  task automatic single_loopback();
    chan_pkg::chan_word_t sent;
    chan_pkg::chan_word_t got;
    logic                 irq_seen;
    cur_test = "single loopback";
    sent = '{data: $urandom(), last: 1'b1};
    send_one(sent);
    wait_for("irq", 1'b1);
    recv_one(got, irq_seen);
    check_word("returned word", sent, got);
    check_bit("irq with word", 1'b1, irq_seen);
    @(posedge CPU_CLK);
    check_bit("irq after ack", 1'b0, irq);
  endtask

  task automatic frame_order();
    chan_pkg::chan_word_t sent [4];
    chan_pkg::chan_word_t got;
    logic                 irq_seen;
    cur_test = "frame order";
    for (int i = 0; i < 4; i++) begin
      sent[i] = '{data: $urandom(), last: (i == 3)};
      send_one(sent[i]);
    end
    // each word is drained well before the next one lands.
    for (int i = 0; i < 4; i++) begin
      recv_one(got, irq_seen);
      check_word("frame word", sent[i], got);
      check_bit("irq", (i == 3), irq_seen);
    end
  endtask

  task automatic overflow_recovery();
    chan_pkg::chan_word_t sent [6];
    chan_pkg::chan_word_t got;
    logic                 irq_seen;
    cur_test = "overflow";
    for (int i = 0; i < 6; i++) begin
      sent[i] = '{data: $urandom(), last: (i == 3)};
      send_one(sent[i]);
    end
    wait_line_idle(); // words 5 and 6 meet a full receive buffer.
    check_bit("err after overflow", 1'b1, err);
    check_bit("irq with frame held", 1'b1, irq);
    err_ack <= 1'b1;
    wait_for("err", 1'b0);
    err_ack <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      recv_one(got, irq_seen);
      check_word("kept word", sent[i], got);
      check_bit("irq with kept word", 1'b1, irq_seen); // word 4 ends the frame.
    end
    repeat (4) @(posedge CPU_CLK);
    check_bit("recv_req after drain", 1'b0, recv_req);
    check_bit("err after drain", 1'b0, err);
  endtask

  task automatic framing_errors();
    chan_pkg::chan_word_t known;
    chan_pkg::chan_word_t got;
    logic                 irq_seen;
    cur_test = "framing";
    known = '{data: 32'h5a3c_e107, last: 1'b1};
    @(posedge CPU_CLK);
    loop_en <= 1'b0;
    drive_frame({1'b0, known.last, known.data, 1'b0}); // stop bit low.
    for (int i = 0; i < net_pkg::FRAME_BITS; i++) begin
      @(posedge CPU_CLK);
      check_bit("recv_req after bad stop", 1'b0, recv_req);
    end
    drive_frame({1'b1, known.last, known.data, 1'b0});
    recv_one(got, irq_seen);
    check_word("framed word", known, got);
    check_bit("irq with framed word", 1'b1, irq_seen);
    loop_en <= 1'b1;
  endtask

  task automatic send_backpressure();
    chan_pkg::chan_word_t sent [8];
    chan_pkg::chan_word_t got;
    logic                 irq_seen;
    cur_test = "send back-pressure";
    for (int i = 0; i < 8; i++) begin
      sent[i] = '{data: $urandom(), last: (i == 7)};
      send_one(sent[i]);
      // words 2 to 5 fill the transmit buffer while the first is on the wire.
      if (i == 5) check_bit("sixth ack held off", 1'b1, ack_wait > 2);
    end
    for (int i = 0; i < 8; i++) begin
      recv_one(got, irq_seen);
      check_word("queued word", sent[i], got);
      check_bit("irq", (i == 7), irq_seen);
    end
    check_bit("err", 1'b0, err);
  endtask

// File: verification/chip_tb.sv
module chip_tb;

  localparam int WAIT_LIMIT = 600; // longest any single wait may run, in cycles.

  logic                 CPU_CLK;
  logic                 RST;
  logic                 ready;
  logic                 send_req;
  chan_pkg::chan_word_t send_word;
  logic                 send_ack;
  logic                 recv_req;
  chan_pkg::chan_word_t recv_word;
  logic                 recv_ack;
  logic                 err;
  logic                 err_ack;
  logic                 irq;
  logic                 wire_rx;
  logic                 wire_tx;
  logic                 loop_en;
  logic                 drv_rx;
  string                cur_test;
  int                   waited;
  int                   ack_wait; // edges the last send waited for its ack.

  chip UUT (.CPU_CLK, .RST, .ready, .send_req, .send_word, .send_ack, .recv_req,
            .recv_word, .recv_ack, .err, .err_ack, .irq, .wire_rx, .wire_tx);

  assign wire_rx = loop_en ? wire_tx : drv_rx; // loopback unless a test drives the line.

  initial begin
    CPU_CLK = 1'b0;
    forever #4 CPU_CLK = ~CPU_CLK;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input chan_pkg::chan_word_t exp,
                            input chan_pkg::chan_word_t act);
    if (act !== exp)
      abort_run($sformatf("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act));
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("FAILED %s: %s expected %b actual %b", cur_test, what, exp, act));
  endtask

  `include "chip_tests.svh"

  initial begin
    RST       = 1'b0;
    send_req  = 1'b0;
    send_word = '0;
    recv_ack  = 1'b0;
    err_ack   = 1'b0;
    loop_en   = 1'b1;
    drv_rx    = 1'b1;
    void'($urandom(32'h8589));
    repeat (2) @(posedge CPU_CLK);
    RST <= 1'b1;
    reset_values();
    single_loopback();
    frame_order();
    overflow_recovery();
    framing_errors();
    send_backpressure();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: files.f
+incdir+verification
rtl/chan_pkg.sv
rtl/net_pkg.sv
rtl/reset_sequencer.sv
rtl/host_port.sv
rtl/lsab_buffer.sv
rtl/frame_sender.sv
rtl/frame_receiver.sv
rtl/chip.sv
verification/chip_tb.sv
